// File: logic/lc4_isa_pkg.sv
package lc4_isa_pkg;

   localparam int WORD_W    = 16;          // data and address width
   localparam int REG_SEL_W = 3;           // eight registers

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;

   // top nibble of the instruction, only the kept subset
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_AND   = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001,
      OP_JMP   = 4'b1100
   } opcode_e;

   localparam int OPC_LSB   = 12;
   localparam int RD_LSB    = 9;           // also rt of STR and nzp of BR
   localparam int RS_LSB    = 6;
   localparam int RT_LSB    = 0;
   localparam int SUBOP_LSB = 3;           // bits 5:3, bit 5 flags the imm5 form
   localparam int SUBOP_W   = 3;
   localparam int IMM5_W    = 5;
   localparam int IMM6_W    = 6;
   localparam int IMM9_W    = 9;
   localparam int IMM11_W   = 11;

   localparam logic [SUBOP_W-1:0] SUB_BASE = 3'b000; // ADD in arith, AND in logic
   localparam logic [SUBOP_W-1:0] SUB_SUB  = 3'b010;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_PASS_B} alu_op_e;

   localparam word_t RESET_PC = 16'h8200;
   localparam word_t NOP_INSN = '0;        // BR with nzp 000, never taken

endpackage

// File: logic/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

   // where an X operand comes from
   typedef enum logic [1:0] {
      FWD_REG,       // value read from the regfile in D
      FWD_M,         // alu result sitting in M
      FWD_W          // writeback value in W
   } fwd_sel_e;

   // writeback value source
   typedef enum logic {
      WB_ALU,
      WB_MEM
   } wb_src_e;

   localparam int NZP_W = 3;  // n z p, msb first

endpackage

// File: logic/lc4_decoder.sv
module lc4_decoder import lc4_isa_pkg::*; (
   input  word_t    i_insn,
   output reg_sel_t o_rs,
   output reg_sel_t o_rt,
   output logic     o_rs_re,
   output logic     o_rt_re,
   output reg_sel_t o_rd,
   output logic     o_rd_we,
   output alu_op_e  o_alu_op,
   output logic     o_use_imm,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_is_br,
   output logic     o_is_jmp
);

   opcode_e            opc;
   logic [SUBOP_W-1:0] subop;

   assign opc   = opcode_e'(i_insn[OPC_LSB +: 4]);
   assign subop = i_insn[SUBOP_LSB +: SUBOP_W];

   always_comb begin
      o_rs       = i_insn[RS_LSB +: REG_SEL_W];
      o_rt       = i_insn[RT_LSB +: REG_SEL_W];
      o_rd       = i_insn[RD_LSB +: REG_SEL_W];
      o_rs_re    = 1'b0;
      o_rt_re    = 1'b0;
      o_rd_we    = 1'b0;
      o_alu_op   = ALU_ADD;
      o_use_imm  = 1'b0;
      o_is_load  = 1'b0;
      o_is_store = 1'b0;
      o_is_br    = 1'b0;
      o_is_jmp   = 1'b0;
      case (opc)
         OP_BR: o_is_br = |i_insn[RD_LSB +: 3];   // nzp 000 is the nop
         OP_ARITH, OP_AND: begin
            // imm5 form, or the register forms we keep (ADD/SUB, AND)
            if (subop[SUBOP_W-1] || subop == SUB_BASE || (opc == OP_ARITH && subop == SUB_SUB)) begin
               o_rs_re   = 1'b1;
               o_rt_re   = !subop[SUBOP_W-1];
               o_rd_we   = 1'b1;
               o_use_imm = subop[SUBOP_W-1];
               if (opc == OP_AND)
                  o_alu_op = ALU_AND;
               else if (subop == SUB_SUB)
                  o_alu_op = ALU_SUB;
            end
         end
         OP_LDR: begin
            o_rs_re   = 1'b1;
            o_rd_we   = 1'b1;
            o_use_imm = 1'b1;                       // base + imm6
            o_is_load = 1'b1;
         end
         OP_STR: begin
            o_rt       = i_insn[RD_LSB +: REG_SEL_W]; // store data sits in the rd field
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_use_imm  = 1'b1;
            o_is_store = 1'b1;
         end
         OP_CONST: begin
            o_rd_we   = 1'b1;
            o_use_imm = 1'b1;
            o_alu_op  = ALU_PASS_B;                  // rd <- sext(imm9)
         end
         OP_JMP: o_is_jmp = i_insn[IMM11_W];         // bit 11 low is JMPR, dropped
         default: ;                                  // unsupported, acts as nop
      endcase
   end

endmodule

// File: logic/lc4_pipe_ctrl.sv
module lc4_pipe_ctrl import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  word_t    i_d_insn,
   input  logic     i_x_br_taken,
   output reg_sel_t o_d_rs,          // regfile read selects for D
   output reg_sel_t o_d_rt,
   output logic     o_stall,
   output logic     o_redirect,
   output alu_op_e  o_x_alu_op,
   output logic     o_x_use_imm,
   output fwd_sel_e o_x_src1_sel,
   output fwd_sel_e o_x_src2_sel,
   output logic     o_x_is_br,
   output logic     o_m_we_reg,
   output logic     o_m_dmem_we,
   output logic     o_m_dmem_rd,
   output logic     o_w_we,
   output reg_sel_t o_w_rd,
   output wb_src_e  o_w_src,
   output logic     o_m_st_fwd
);

   // decoded D fields
   logic     d_rs_re, d_rt_re, d_rd_we, d_use_imm;
   logic     d_is_load, d_is_store, d_is_br, d_is_jmp;
   reg_sel_t d_rd;
   alu_op_e  d_alu_op;

   // pipelined control, one set per stage
   reg_sel_t x_rs, x_rt, x_rd, m_rt, m_rd, w_rd;
   logic     x_we, x_load, x_store, x_br, x_jmp, x_use_imm;
   logic     m_we, m_load, m_store, w_we, w_load;
   alu_op_e  x_alu_op;
   logic     load_use, redirect;

   lc4_decoder u_dec (
      .i_insn     (i_d_insn),
      .o_rs       (o_d_rs),
      .o_rt       (o_d_rt),
      .o_rs_re    (d_rs_re),
      .o_rt_re    (d_rt_re),
      .o_rd       (d_rd),
      .o_rd_we    (d_rd_we),
      .o_alu_op   (d_alu_op),
      .o_use_imm  (d_use_imm),
      .o_is_load  (d_is_load),
      .o_is_store (d_is_store),
      .o_is_br    (d_is_br),
      .o_is_jmp   (d_is_jmp)
   );

   // load in X feeding D, except the data operand of a store (W to M covers it)
   assign load_use = x_load && ((d_rs_re && o_d_rs == x_rd) ||
                                (d_rt_re && !d_is_store && o_d_rt == x_rd));
   assign redirect = x_jmp || (x_br && i_x_br_taken);

   always_ff @(posedge gwe) begin
      if (!i_rst_n || load_use || redirect) begin  // bubble into X
         x_rs      <= '0;
         x_rt      <= '0;
         x_rd      <= '0;
         x_we      <= 1'b0;
         x_load    <= 1'b0;
         x_store   <= 1'b0;
         x_br      <= 1'b0;
         x_jmp     <= 1'b0;
         x_use_imm <= 1'b0;
         x_alu_op  <= ALU_ADD;
      end else begin
         x_rs      <= o_d_rs;
         x_rt      <= o_d_rt;
         x_rd      <= d_rd;
         x_we      <= d_rd_we;
         x_load    <= d_is_load;
         x_store   <= d_is_store;
         x_br      <= d_is_br;
         x_jmp     <= d_is_jmp;
         x_use_imm <= d_use_imm;
         x_alu_op  <= d_alu_op;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_we    <= 1'b0;
         m_load  <= 1'b0;
         m_store <= 1'b0;
         w_we    <= 1'b0;
         w_load  <= 1'b0;
      end else begin
         m_we    <= x_we;
         m_load  <= x_load;
         m_store <= x_store;
         w_we    <= m_we;
         w_load  <= m_load;
      end
      m_rt <= x_rt;   // selects only matter with their enables
      m_rd <= x_rd;
      w_rd <= m_rd;
   end

   // youngest producer wins
   assign o_x_src1_sel = (m_we && m_rd == x_rs) ? FWD_M :
                         (w_we && w_rd == x_rs) ? FWD_W : FWD_REG;
   assign o_x_src2_sel = (m_we && m_rd == x_rt) ? FWD_M :
                         (w_we && w_rd == x_rt) ? FWD_W : FWD_REG;

   assign o_m_st_fwd  = m_store && w_load && m_rt == w_rd; // load then store of its rd
   assign o_stall     = load_use;
   assign o_redirect  = redirect;
   assign o_x_alu_op  = x_alu_op;
   assign o_x_use_imm = x_use_imm;
   assign o_x_is_br   = x_br;
   assign o_m_we_reg  = m_we;
   assign o_m_dmem_we = m_store;
   assign o_m_dmem_rd = m_load;
   assign o_w_we      = w_we;
   assign o_w_rd      = w_rd;
   assign o_w_src     = w_load ? WB_MEM : WB_ALU;

endmodule

// File: logic/lc4_fetch.sv
module lc4_fetch import lc4_isa_pkg::*; (
   input  logic  gwe,
   input  logic  i_rst_n,
   input  logic  i_stall,
   input  logic  i_redirect,
   input  word_t i_target,
   input  word_t i_imem_insn,
   output word_t o_pc,
   output word_t o_d_insn,
   output word_t o_d_pc
);

   word_t pc_q;

   always_ff @(posedge gwe) begin
      if (!i_rst_n)
         pc_q <= RESET_PC;
      else if (i_redirect)
         pc_q <= i_target;                    // branch or jmp resolved in X
      else if (!i_stall)
         pc_q <= pc_q + word_t'(1);
   end

   // F/D register, flushed on redirect and held on stall
   always_ff @(posedge gwe) begin
      if (!i_rst_n || i_redirect)
         o_d_insn <= NOP_INSN;
      else if (!i_stall)
         o_d_insn <= i_imem_insn;
   end

   always_ff @(posedge gwe) begin
      if (!i_stall)
         o_d_pc <= pc_q;
   end

   assign o_pc = pc_q;

endmodule

// File: logic/lc4_regfile.sv
module lc4_regfile import lc4_isa_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  reg_sel_t i_rs,
   input  reg_sel_t i_rt,
   output word_t    o_rs_data,
   output word_t    o_rt_data,
   input  reg_sel_t i_rd,
   input  word_t    i_wdata,
   input  logic     i_we
);

   word_t regs [1 << REG_SEL_W];

   always_ff @(posedge gwe) begin
      if (!i_rst_n)
         regs <= '{default: '0};
      else if (i_we)
         regs[i_rd] <= i_wdata;
   end

   // write-through gives the W to D bypass
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: logic/lc4_execute.sv
module lc4_execute import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  logic     i_stall,
   input  logic     i_redirect,
   input  word_t    i_d_insn,
   input  word_t    i_d_pc,
   input  word_t    i_rs_data,
   input  word_t    i_rt_data,
   input  alu_op_e  i_alu_op,
   input  logic     i_use_imm,
   input  fwd_sel_e i_src1_sel,
   input  fwd_sel_e i_src2_sel,
   input  logic     i_is_br,
   input  word_t    i_m_fwd,      // alu result in M
   input  word_t    i_w_fwd,      // writeback value
   input  logic     i_m_nzp_we,
   input  word_t    i_m_final,
   output word_t    o_result,
   output word_t    o_store_data,
   output word_t    o_target,
   output logic     o_br_taken
);

   word_t             x_insn, x_pc, x_rs_q, x_rt_q;
   word_t             opa, opb_reg, opb, imm, offset;
   opcode_e           x_opc;
   logic [NZP_W-1:0]  nzp_q, nzp_m, nzp_cur;

   function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t m_val, word_t w_val);
      case (sel)
         FWD_M:   return m_val;
         FWD_W:   return w_val;
         default: return reg_val;
      endcase
   endfunction

   function automatic logic [NZP_W-1:0] nzp_of(word_t v);
      if (v[WORD_W-1])
         return 3'b100;
      else if (v == '0)
         return 3'b010;
      else
         return 3'b001;
   endfunction

   always_ff @(posedge gwe) begin
      if (!i_rst_n || i_stall || i_redirect)
         x_insn <= NOP_INSN;                   // bubble
      else
         x_insn <= i_d_insn;
   end

   always_ff @(posedge gwe) begin
      x_pc   <= i_d_pc;
      x_rs_q <= i_rs_data;
      x_rt_q <= i_rt_data;
   end

   assign x_opc   = opcode_e'(x_insn[OPC_LSB +: 4]);
   assign opa     = fwd_mux(i_src1_sel, x_rs_q, i_m_fwd, i_w_fwd);
   assign opb_reg = fwd_mux(i_src2_sel, x_rt_q, i_m_fwd, i_w_fwd);
   assign opb     = i_use_imm ? imm : opb_reg;

   // immediate width by format
   always_comb begin
      case (x_opc)
         OP_ARITH, OP_AND: imm = word_t'(signed'(x_insn[IMM5_W-1:0]));
         OP_LDR, OP_STR:   imm = word_t'(signed'(x_insn[IMM6_W-1:0]));
         OP_CONST:         imm = word_t'(signed'(x_insn[IMM9_W-1:0]));
         default:          imm = '0;
      endcase
   end

   always_comb begin
      case (i_alu_op)
         ALU_ADD:    o_result = opa + opb;     // also the LDR/STR address
         ALU_SUB:    o_result = opa - opb;
         ALU_AND:    o_result = opa & opb;
         default:    o_result = opb;           // CONST
      endcase
   end

   assign offset = (x_opc == OP_JMP) ? word_t'(signed'(x_insn[IMM11_W-1:0]))
                                      : word_t'(signed'(x_insn[IMM9_W-1:0]));
   assign o_target     = x_pc + word_t'(1) + offset;
   assign o_store_data = opb_reg;

   // nzp from the final value in M, loads included
   assign nzp_m = nzp_of(i_m_final);

   always_ff @(posedge gwe) begin
      if (!i_rst_n)
         nzp_q <= '0;
      else if (i_m_nzp_we)
         nzp_q <= nzp_m;
   end

   assign nzp_cur    = i_m_nzp_we ? nzp_m : nzp_q;  // M is the next older insn
   assign o_br_taken = i_is_br && |(x_insn[RD_LSB +: NZP_W] & nzp_cur);

endmodule

// File: logic/lc4_mem_wb.sv
module lc4_mem_wb import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic    gwe,
   input  logic    i_rst_n,
   input  word_t   i_result,
   input  word_t   i_store_data,
   input  word_t   i_dmem_rdata,
   input  logic    i_m_dmem_rd,
   input  logic    i_st_fwd,
   input  wb_src_e i_w_src,
   output word_t   o_dmem_addr,
   output word_t   o_dmem_wdata,
   output word_t   o_m_final,
   output word_t   o_w_data
);

   word_t m_result, m_store_q;   // X/M
   word_t w_alu, w_mem;          // M/W

   // cleared so the memory bus is quiet in reset
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_result  <= '0;
         m_store_q <= '0;
         w_alu     <= '0;
         w_mem     <= '0;
      end else begin
         m_result  <= i_result;
         m_store_q <= i_store_data;
         w_alu     <= m_result;
         w_mem     <= i_dmem_rdata;
      end
   end

   assign o_dmem_addr  = m_result;
   assign o_dmem_wdata = i_st_fwd ? o_w_data : m_store_q;  // load in W feeds the store
   assign o_m_final    = i_m_dmem_rd ? i_dmem_rdata : m_result;
   assign o_w_data     = (i_w_src == WB_MEM) ? w_mem : w_alu;

endmodule

// File: logic/lc4_pipe_top.sv
module lc4_pipe_top import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   output word_t    o_imem_addr,
   input  word_t    i_imem_insn,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   input  word_t    i_dmem_rdata,
   output logic     o_wb_we,
   output reg_sel_t o_wb_sel,
   output word_t    o_wb_data
);

   word_t    d_insn, d_pc, rs_data, rt_data, target;
   word_t    x_result, x_store_data, m_result, m_final, w_data;
   reg_sel_t d_rs, d_rt, w_rd;
   logic     stall, redirect, br_taken, x_use_imm, x_is_br;
   logic     m_we_reg, m_dmem_rd, st_fwd, w_we;
   alu_op_e  x_alu_op;
   fwd_sel_e src1_sel, src2_sel;
   wb_src_e  w_src;

   lc4_pipe_ctrl u_ctrl (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_d_insn     (d_insn),
      .i_x_br_taken (br_taken),
      .o_d_rs       (d_rs),
      .o_d_rt       (d_rt),
      .o_stall      (stall),
      .o_redirect   (redirect),
      .o_x_alu_op   (x_alu_op),
      .o_x_use_imm  (x_use_imm),
      .o_x_src1_sel (src1_sel),
      .o_x_src2_sel (src2_sel),
      .o_x_is_br    (x_is_br),
      .o_m_we_reg   (m_we_reg),
      .o_m_dmem_we  (o_dmem_we),
      .o_m_dmem_rd  (m_dmem_rd),
      .o_w_we       (w_we),
      .o_w_rd       (w_rd),
      .o_w_src      (w_src),
      .o_m_st_fwd   (st_fwd)
   );

   lc4_fetch u_fetch (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_stall     (stall),
      .i_redirect  (redirect),
      .i_target    (target),
      .i_imem_insn (i_imem_insn),
      .o_pc        (o_imem_addr),
      .o_d_insn    (d_insn),
      .o_d_pc      (d_pc)
   );

   lc4_regfile u_rf (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (d_rs),
      .i_rt      (d_rt),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_rd      (w_rd),
      .i_wdata   (w_data),
      .i_we      (w_we)
   );

   lc4_execute u_ex (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_stall      (stall),
      .i_redirect   (redirect),
      .i_d_insn     (d_insn),
      .i_d_pc       (d_pc),
      .i_rs_data    (rs_data),
      .i_rt_data    (rt_data),
      .i_alu_op     (x_alu_op),
      .i_use_imm    (x_use_imm),
      .i_src1_sel   (src1_sel),
      .i_src2_sel   (src2_sel),
      .i_is_br      (x_is_br),
      .i_m_fwd      (m_result),
      .i_w_fwd      (w_data),
      .i_m_nzp_we   (m_we_reg),
      .i_m_final    (m_final),
      .o_result     (x_result),
      .o_store_data (x_store_data),
      .o_target     (target),
      .o_br_taken   (br_taken)
   );

   lc4_mem_wb u_mw (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_result     (x_result),
      .i_store_data (x_store_data),
      .i_dmem_rdata (i_dmem_rdata),
      .i_m_dmem_rd  (m_dmem_rd),
      .i_st_fwd     (st_fwd),
      .i_w_src      (w_src),
      .o_dmem_addr  (m_result),
      .o_dmem_wdata (o_dmem_wdata),
      .o_m_final    (m_final),
      .o_w_data     (w_data)
   );

   assign o_dmem_addr = m_result;
   assign o_wb_we     = w_we;   // trace port
   assign o_wb_sel    = w_rd;
   assign o_wb_data   = w_data;

endmodule

// File: testbench/lc4_asserts.sv
module lc4_asserts (
   input logic        gwe,
   input logic        i_rst_n,
   input logic        i_stall,
   input logic        i_redirect,
   input logic [15:0] i_d_insn,
   input logic        i_m_dmem_we,
   input logic        i_w_we
);

   // a load-use stall keeps the same instruction in D for another look
   d_held_on_stall: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_stall |=> $stable(i_d_insn))
      else $error("D instruction changed across a load-use stall");

   d_flushed_on_redirect: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_redirect |=> (i_d_insn == '0))   // nop is all zeros
      else $error("D instruction not squashed after a taken branch or jmp");

   // first insn reaches M three edges after reset, W four
   quiet_after_reset: assert property (@(posedge gwe)
      (i_rst_n && !$past(i_rst_n, 3)) |-> (!i_w_we && !i_m_dmem_we))
      else $error("write enable high in the first cycles after reset");

   known_w_we: assert property (@(posedge gwe)
      i_rst_n |-> !$isunknown(i_w_we))   // X on the trace enable
      else $error("writeback enable is unknown out of reset");

endmodule

bind lc4_pipe_ctrl lc4_asserts u_asserts (
   .gwe         (gwe),
   .i_rst_n     (i_rst_n),
   .i_stall     (o_stall),
   .i_redirect  (o_redirect),
   .i_d_insn    (i_d_insn),
   .i_m_dmem_we (o_m_dmem_we),
   .i_w_we      (o_w_we)
);

// File: testbench/lc4_checker.sv
module lc4_checker import lc4_isa_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  logic     i_wb_we,
   input  reg_sel_t i_wb_sel,
   input  word_t    i_wb_data,
   input  logic     i_dmem_we,
   input  word_t    i_dmem_addr,
   input  word_t    i_dmem_wdata,
   output logic     o_done,
   output int       o_errors,
   output int       o_wb_seen,
   output int       o_st_seen
);

   localparam int QUIET_CYCLES = 4;   // first writeback can land after the 4th edge
   localparam int DRAIN_CYCLES = 8;   // watch for stray writes once the lists run dry

   logic [18:0] wb_q [$];             // {sel, data}
   logic [31:0] st_q [$];             // {addr, data}
   int          since_rst = 0;
   int          drained   = 0;

   initial begin
      o_done    = 1'b0;
      o_errors  = 0;
      o_wb_seen = 0;
      o_st_seen = 0;
   end

   task automatic expect_write(reg_sel_t sel, word_t data);
      wb_q.push_back({sel, data});
   endtask

   task automatic expect_store(word_t addr, word_t data);
      st_q.push_back({addr, data});
   endtask

   task automatic compare_value(string name, word_t exp, word_t act);
      if (act !== exp) begin
         o_errors++;
         $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   // edges since reset went away, counted where rst_n is stable
   always @(posedge gwe) begin
      if (!i_rst_n)
         since_rst <= 0;
      else if (since_rst < QUIET_CYCLES)
         since_rst <= since_rst + 1;
   end

   // outputs are settled mid-cycle
   always @(negedge gwe) begin
      logic [18:0] wb;
      logic [31:0] st;
      if (since_rst < QUIET_CYCLES) begin
         if (i_wb_we !== 1'b0 || i_dmem_we !== 1'b0) begin
            o_errors++;
            $display("a write enable was not low during reset or just after it, t=%0t", $time);
         end
      end else begin
         if (i_wb_we) begin
            o_wb_seen++;
            if (wb_q.size() == 0) begin
               o_errors++;
               $display("register write to r%0d with none expected, t=%0t", i_wb_sel, $time);
            end else begin
               wb = wb_q.pop_front();
               compare_value("o_wb_sel", word_t'(wb[18:16]), word_t'(i_wb_sel));
               compare_value("o_wb_data", wb[15:0], i_wb_data);
            end
         end
         if (i_dmem_we) begin
            o_st_seen++;
            if (st_q.size() == 0) begin
               o_errors++;
               $display("store to %h with none expected, t=%0t", i_dmem_addr, $time);
            end else begin
               st = st_q.pop_front();
               compare_value("o_dmem_addr", st[31:16], i_dmem_addr);
               compare_value("o_dmem_wdata", st[15:0], i_dmem_wdata);
            end
         end
         if (wb_q.size() == 0 && st_q.size() == 0)
            drained++;
         else
            drained = 0;
         o_done = (drained >= DRAIN_CYCLES);
      end
   end

endmodule

// File: testbench/lc4_tb.sv
module lc4_tb import lc4_isa_pkg::*; ();

   localparam int N_INSN      = 48;
   localparam int IMEM_WORDS  = 64;
   localparam int HALF_PERIOD = 20;
   localparam int RST_CYCLES  = 10;
   localparam int WDOG_CYCLES = RST_CYCLES + 4 * N_INSN * 3 + 50; // worst cpi plus drain

   logic     gwe;
   logic     rst_n;
   word_t    imem_addr, imem_insn, dmem_addr, dmem_wdata, dmem_rdata, wb_data;
   logic     dmem_we, wb_we, chk_done;
   reg_sel_t wb_sel;
   int       err_cnt, wb_cnt, st_cnt;

   word_t imem [IMEM_WORDS];   // program at RESET_PC
   word_t dmem [256];

   word_t       m_regs [8];    // isa model state
   word_t       m_mem [256];
   logic [2:0]  m_nzp;
   word_t       m_pc;
   logic [31:0] rng;

   lc4_pipe_top UUT (
      .gwe          (gwe),
      .i_rst_n      (rst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_insn  (imem_insn),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_we    (dmem_we),
      .o_dmem_wdata (dmem_wdata),
      .i_dmem_rdata (dmem_rdata),
      .o_wb_we      (wb_we),
      .o_wb_sel     (wb_sel),
      .o_wb_data    (wb_data)
   );

   lc4_checker u_chk (
      .gwe          (gwe),
      .i_rst_n      (rst_n),
      .i_wb_we      (wb_we),
      .i_wb_sel     (wb_sel),
      .i_wb_data    (wb_data),
      .i_dmem_we    (dmem_we),
      .i_dmem_addr  (dmem_addr),
      .i_dmem_wdata (dmem_wdata),
      .o_done       (chk_done),
      .o_errors     (err_cnt),
      .o_wb_seen    (wb_cnt),
      .o_st_seen    (st_cnt)
   );

   // both memories answer in the same cycle
   assign imem_insn  = (imem_addr[15:6] == RESET_PC[15:6]) ? imem[imem_addr[5:0]] : NOP_INSN;
   assign dmem_rdata = dmem[dmem_addr[7:0]];

   always @(negedge gwe) begin
      if (dmem_we)
         dmem[dmem_addr[7:0]] <= dmem_wdata;   // store from M, mid-cycle
   end

   function automatic logic [31:0] xorshift(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // event record {kind, sel or addr, data}, kind 1 reg write, 2 store
   function automatic logic [33:0] reg_write(reg_sel_t sel, word_t val);
      m_regs[sel] = val;
      m_nzp = val[15] ? 3'b100 : ((val == '0) ? 3'b010 : 3'b001);
      return {2'd1, 13'd0, sel, val};
   endfunction

   // one instruction of the isa, in program order
   function automatic logic [33:0] ref_step(word_t insn);
      word_t       a, b, addr;
      logic [33:0] ev;
      ev   = '0;
      a    = m_regs[insn[8:6]];
      b    = m_regs[insn[2:0]];
      addr = a + {{10{insn[5]}}, insn[5:0]};     // ldr/str base + imm6
      m_pc = m_pc + 16'd1;
      case (opcode_e'(insn[15:12]))
         OP_ARITH: begin
            if (insn[5])
               b = {{11{insn[4]}}, insn[4:0]};
            ev = reg_write(insn[11:9], (insn[5:3] == 3'b010) ? a - b : a + b);
         end
         OP_AND: begin
            if (insn[5])
               b = {{11{insn[4]}}, insn[4:0]};
            ev = reg_write(insn[11:9], a & b);
         end
         OP_LDR:   ev = reg_write(insn[11:9], m_mem[addr[7:0]]);
         OP_STR: begin
            m_mem[addr[7:0]] = m_regs[insn[11:9]];
            ev = {2'd2, addr, m_regs[insn[11:9]]};
         end
         OP_CONST: ev = reg_write(insn[11:9], {{7{insn[8]}}, insn[8:0]});
         OP_BR: begin
            if (|(insn[11:9] & m_nzp))
               m_pc = m_pc + {{7{insn[8]}}, insn[8:0]};
         end
         OP_JMP:   m_pc = m_pc + {{5{insn[10]}}, insn[10:0]};
         default: ;
      endcase
      return ev;
   endfunction

   task automatic gen_program();
      logic [3:0] kind;
      reg_sel_t   rd, rs, rt, last_rd;
      logic [2:0] nzp;
      int         off;
      last_rd = '0;
      for (int i = 0; i < IMEM_WORDS; i++)
         imem[i] = NOP_INSN;                     // fetch past the end sees nops
      for (int i = 0; i < N_INSN; i++) begin
         rng  = xorshift(rng);
         kind = (i == 0) ? 4'd7 : rng[10:7];      // start with a const
         rd   = rng[2:0];
         rs   = rng[3] ? last_rd : rng[6:4];      // lean on the last result for hazards
         rt   = rng[11] ? last_rd : rng[14:12];
         nzp  = (rng[26:24] == 3'b000) ? 3'b010 : rng[26:24];
         off  = int'(rng[28:27]);
         if (off > N_INSN - 1 - i)
            off = N_INSN - 1 - i;                 // target stays inside the program
         case (kind)
            4'd0, 4'd1:   imem[i] = {4'b0001, rd, rs, 3'b000, rt};
            4'd2:         imem[i] = {4'b0001, rd, rs, 3'b010, rt};       // sub
            4'd3:         imem[i] = {4'b0101, rd, rs, 3'b000, rt};
            4'd4, 4'd5:   imem[i] = {4'b0001, rd, rs, 1'b1, rng[19:15]};
            4'd6:         imem[i] = {4'b0101, rd, rs, 1'b1, rng[19:15]};
            4'd7, 4'd8:   imem[i] = {4'b1001, rd, rng[23:15]};
            4'd9, 4'd10:  imem[i] = {4'b0110, rd, rs, rng[20:15]};        // ldr
            4'd11, 4'd12: imem[i] = {4'b0111, rt, rs, rng[20:15]};        // str, rt is data
            4'd13, 4'd14: imem[i] = {4'b0000, nzp, 9'(off)};
            default:      imem[i] = {4'b1100, 1'b1, 11'(off)};            // jmp
         endcase
         if (kind <= 4'd10)
            last_rd = rd;
      end
      imem[N_INSN] = {4'b1100, 1'b1, 11'h7ff};   // jmp to itself ends the program
   endtask

   task automatic run_model();
      logic [33:0] ev;
      for (int a = 0; a < 256; a++) begin
         dmem[a]  = {8'(a) ^ 8'h5a, 8'(a * 37 + 11)};
         m_mem[a] = dmem[a];
      end
      for (int r = 0; r < 8; r++)
         m_regs[r] = '0;
      m_nzp = 3'b000;
      m_pc  = RESET_PC;
      while (m_pc != RESET_PC + word_t'(N_INSN)) begin
         ev = ref_step(imem[6'(m_pc - RESET_PC)]);
         if (ev[33:32] == 2'd1)
            u_chk.expect_write(reg_sel_t'(ev[18:16]), ev[15:0]);
         else if (ev[33:32] == 2'd2)
            u_chk.expect_store(ev[31:16], ev[15:0]);
      end
   endtask

   initial begin
      gwe = 1'b0;
      forever #HALF_PERIOD gwe = ~gwe;
   end

   initial begin
      rst_n = 1'b0;
      rng   = 32'h049e_90d3;
      gen_program();
      run_model();
      repeat (RST_CYCLES) @(negedge gwe);
      rst_n = 1'b1;
      wait (chk_done);
      @(negedge gwe);
      $display("checked %0d register writes and %0d stores, %0d errors", wb_cnt, st_cnt, err_cnt);
      if (err_cnt == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      repeat (WDOG_CYCLES) @(posedge gwe);
      $display("timeout, the program did not finish within %0d cycles", WDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: src.f
logic/lc4_isa_pkg.sv
logic/lc4_pipe_pkg.sv
logic/lc4_decoder.sv
logic/lc4_pipe_ctrl.sv
logic/lc4_fetch.sv
logic/lc4_regfile.sv
logic/lc4_execute.sv
logic/lc4_mem_wb.sv
logic/lc4_pipe_top.sv
testbench/lc4_asserts.sv
testbench/lc4_checker.sv
testbench/lc4_tb.sv

// File: Bender.yml
package:
  name: lc4_pipe

sources:
  - logic/lc4_isa_pkg.sv
  - logic/lc4_pipe_pkg.sv
  - logic/lc4_decoder.sv
  - logic/lc4_pipe_ctrl.sv
  - logic/lc4_fetch.sv
  - logic/lc4_regfile.sv
  - logic/lc4_execute.sv
  - logic/lc4_mem_wb.sv
  - logic/lc4_pipe_top.sv
  - target: test
    files:
      - testbench/lc4_asserts.sv
      - testbench/lc4_checker.sv
      - testbench/lc4_tb.sv
